// File: rtl/sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// Width of the AXI data bus and of one array word
`define SRAM_DATA_BITS 32

// Number of byte lanes in one data word, one strobe bit per lane
`define SRAM_DATA_BYTES (`SRAM_DATA_BITS / 8)

// Width of the AXI address bus
`define SRAM_ADDR_BITS 32

// Byte address width of the array, 12 bits gives 4 KiB of storage
`define SRAM_ABITS 12

// Low address bits that select a byte inside a word
`define SRAM_WORD_LSB $clog2(`SRAM_DATA_BYTES)

// Word index width, which sets the array depth
`define SRAM_WADDR_BITS (`SRAM_ABITS - `SRAM_WORD_LSB)

`endif

// File: rtl/axi4_pkg.sv
`include "sram_macros.svh"

package axi4_pkg;

  // Only the two responses this slave can give are listed
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi4_resp_e;

  // Write address channel, single beat and no ID
  typedef struct packed {
    logic                       valid;
    logic [`SRAM_ADDR_BITS-1:0] addr;
  } axi4_aw_t;

  // Write data channel with one strobe bit per byte lane
  typedef struct packed {
    logic                        valid;
    logic [`SRAM_DATA_BITS-1:0]  data;
    logic [`SRAM_DATA_BYTES-1:0] strb;
  } axi4_w_t;

  // Read address channel
  typedef struct packed {
    logic                       valid;
    logic [`SRAM_ADDR_BITS-1:0] addr;
  } axi4_ar_t;

  // Everything the master drives toward the slave
  typedef struct packed {
    axi4_aw_t aw;
    axi4_w_t  w;
    axi4_ar_t ar;
    logic     bready;
    logic     rready;
  } axi4_m2s_t;

  // Everything the slave drives back toward the master
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       arready;
    logic                       bvalid;
    axi4_resp_e                 bresp;
    logic                       rvalid;
    logic [`SRAM_DATA_BITS-1:0] rdata;
    axi4_resp_e                 rresp;
  } axi4_s2m_t;

endpackage

// File: rtl/sram_pkg.sv
`include "sram_macros.svh"

package sram_pkg;

  // Operation handed down the pipeline
  // The DECERR kinds travel through the array stage without touching it
  typedef enum logic [2:0] {
    OP_NONE      = 3'd0,
    OP_READ      = 3'd1,
    OP_WRITE     = 3'd2,
    OP_DECERR_RD = 3'd3,
    OP_DECERR_WR = 3'd4
  } sram_op_e;

  // Request stage to storage stage, valid for one cycle when op is not OP_NONE
  typedef struct packed {
    sram_op_e                    op;
    logic [`SRAM_WADDR_BITS-1:0] addr;
    logic [`SRAM_DATA_BYTES-1:0] strb;
    logic [`SRAM_DATA_BITS-1:0]  wdata;
  } sram_req_t;

  // Storage stage to response stage, the op rides along with the read word
  typedef struct packed {
    sram_op_e                   op;
    logic [`SRAM_DATA_BITS-1:0] rdata;
  } sram_rsp_t;

endpackage

// File: rtl/axi4_req_stage.sv
`timescale 1ns/100ps
`include "sram_macros.svh"

module axi4_req_stage #(
  parameter logic [`SRAM_ADDR_BITS-1:0] XADDR = 32'h0000_8000,
  parameter logic [`SRAM_ADDR_BITS-1:0] XMASK = 32'h0000_0fff
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  axi4_pkg::axi4_m2s_t i_m2s,
  input  logic                i_done,
  output logic                o_awready,
  output logic                o_wready,
  output logic                o_arready,
  output sram_pkg::sram_req_t o_req
);

  // Busy covers the whole span from the handshake to the response handshake
  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e                      state;
  logic                        wr_take;
  logic                        rd_take;
  sram_pkg::sram_op_e          req_op;
  logic [`SRAM_WADDR_BITS-1:0] req_addr;
  logic [`SRAM_DATA_BYTES-1:0] req_strb;
  logic [`SRAM_DATA_BITS-1:0]  req_wdata;

  // The masked address must match the window base exactly
  function automatic logic in_window(input logic [`SRAM_ADDR_BITS-1:0] addr);
    return (addr & ~XMASK) == XADDR;
  endfunction

  // Word index inside the array, byte offset bits dropped
  function automatic logic [`SRAM_WADDR_BITS-1:0] word_idx(
    input logic [`SRAM_ADDR_BITS-1:0] addr
  );
    return addr[`SRAM_WORD_LSB +: `SRAM_WADDR_BITS];
  endfunction

  // A write needs AW and W together, both are taken on the same edge
  assign wr_take   = (state == ST_IDLE) && i_m2s.aw.valid && i_m2s.w.valid;
  assign o_awready = wr_take;
  assign o_wready  = wr_take;

  // A read only goes when no write address is waiting, so writes win
  assign rd_take   = (state == ST_IDLE) && !i_m2s.aw.valid && i_m2s.ar.valid;
  assign o_arready = rd_take;

  // State and the one-cycle op strobe
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state  <= ST_IDLE;
      req_op <= sram_pkg::OP_NONE;
    end else begin
      // The op is a single-cycle pulse toward the array
      req_op <= sram_pkg::OP_NONE;
      if (wr_take) begin
        state  <= ST_BUSY;
        req_op <= in_window(i_m2s.aw.addr) ? sram_pkg::OP_WRITE
                                           : sram_pkg::OP_DECERR_WR;
      end else if (rd_take) begin
        state  <= ST_BUSY;
        req_op <= in_window(i_m2s.ar.addr) ? sram_pkg::OP_READ
                                           : sram_pkg::OP_DECERR_RD;
      end else if (i_done) begin
        // Response accepted by the master, next request may be taken
        state <= ST_IDLE;
      end
    end
  end

  // Address, strobes and data are only looked at while the op is live
  always_ff @(posedge i_clk) begin
    if (wr_take) begin
      req_addr  <= word_idx(i_m2s.aw.addr);
      req_strb  <= i_m2s.w.strb;
      req_wdata <= i_m2s.w.data;
    end else if (rd_take) begin
      req_addr <= word_idx(i_m2s.ar.addr);
      // No lanes enabled on a read
      req_strb <= '0;
    end
  end

  assign o_req = '{
    op:    req_op,
    addr:  req_addr,
    strb:  req_strb,
    wdata: req_wdata
  };

endmodule

// File: rtl/sram_bytes.sv
`timescale 1ns/100ps
`include "sram_macros.svh"

module sram_bytes #(
  parameter int ABITS = `SRAM_ABITS
) (
  input  logic                i_clk,
  input  sram_pkg::sram_req_t i_req,
  output sram_pkg::sram_rsp_t o_rsp
);

  // Word index width derived from the byte address width
  localparam int WBITS = ABITS - `SRAM_WORD_LSB;

  logic [`SRAM_DATA_BITS-1:0] mem [2**WBITS];
  logic [WBITS-1:0]           waddr;
  sram_pkg::sram_op_e         rsp_op;
  logic [`SRAM_DATA_BITS-1:0] rsp_rdata;

  assign waddr = WBITS'(i_req.addr);

  always_ff @(posedge i_clk) begin
    // Only an in-window write changes the array, lane by lane
    if (i_req.op == sram_pkg::OP_WRITE) begin
      for (int i = 0; i < `SRAM_DATA_BYTES; i++) begin
        if (i_req.strb[i]) begin
          mem[waddr][8*i +: 8] <= i_req.wdata[8*i +: 8];
        end
      end
    end
    // Reads outside the window come back as zero
    if (i_req.op == sram_pkg::OP_READ) begin
      rsp_rdata <= mem[waddr];
    end else begin
      rsp_rdata <= '0;
    end
    // The op follows the data by the same one cycle
    rsp_op <= i_req.op;
  end

  assign o_rsp = '{op: rsp_op, rdata: rsp_rdata};

endmodule

// File: rtl/axi4_resp_stage.sv
`timescale 1ns/100ps
`include "sram_macros.svh"

module axi4_resp_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  sram_pkg::sram_rsp_t        i_rsp,
  input  logic                       i_bready,
  input  logic                       i_rready,
  output logic                       o_bvalid,
  output logic                       o_rvalid,
  output axi4_pkg::axi4_resp_e       o_bresp,
  output axi4_pkg::axi4_resp_e       o_rresp,
  output logic [`SRAM_DATA_BITS-1:0] o_rdata,
  output logic                       o_done
);

  logic is_wr;
  logic is_rd;

  // Each op class maps onto exactly one response channel
  assign is_wr = (i_rsp.op == sram_pkg::OP_WRITE) || (i_rsp.op == sram_pkg::OP_DECERR_WR);
  assign is_rd = (i_rsp.op == sram_pkg::OP_READ) || (i_rsp.op == sram_pkg::OP_DECERR_RD);

  // Valid flags rise one edge after the array op and drop on the handshake
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end else if (is_wr) begin
        o_bvalid <= 1'b1;
      end
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end else if (is_rd) begin
        o_rvalid <= 1'b1;
      end
    end
  end

  // Payload loads only when an op arrives
  // Only one transfer is in flight, so it stays put while valid is held
  always_ff @(posedge i_clk) begin
    if (is_wr) begin
      o_bresp <= (i_rsp.op == sram_pkg::OP_WRITE) ? axi4_pkg::OKAY : axi4_pkg::DECERR;
    end
    if (is_rd) begin
      o_rresp <= (i_rsp.op == sram_pkg::OP_READ) ? axi4_pkg::OKAY : axi4_pkg::DECERR;
      o_rdata <= i_rsp.rdata;
    end
  end

  // High in the cycle the master takes the response, frees the request stage
  assign o_done = (o_bvalid && i_bready) || (o_rvalid && i_rready);

endmodule

// File: rtl/axi4_sram.sv
`timescale 1ns/100ps
`include "sram_macros.svh"

module axi4_sram #(
  parameter logic [`SRAM_ADDR_BITS-1:0] XADDR = 32'h0000_8000,
  parameter logic [`SRAM_ADDR_BITS-1:0] XMASK = 32'h0000_0fff,
  parameter int                         ABITS = `SRAM_ABITS
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  axi4_pkg::axi4_m2s_t i_m2s,
  output axi4_pkg::axi4_s2m_t o_s2m
);

  sram_pkg::sram_req_t req;
  sram_pkg::sram_rsp_t rsp;
  logic                done;

  // Accepts AW+W or AR and decodes the window
  axi4_req_stage #(
    .XADDR(XADDR),
    .XMASK(XMASK)
  ) req_stage_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_m2s    (i_m2s),
    .i_done   (done),
    .o_awready(o_s2m.awready),
    .o_wready (o_s2m.wready),
    .o_arready(o_s2m.arready),
    .o_req    (req)
  );

  // Byte-writable storage, one cycle behind the request stage
  sram_bytes #(
    .ABITS(ABITS)
  ) sram_bytes_i (
    .i_clk(i_clk),
    .i_req(req),
    .o_rsp(rsp)
  );

  // Holds B or R until the master takes it
  axi4_resp_stage resp_stage_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_rsp   (rsp),
    .i_bready(i_m2s.bready),
    .i_rready(i_m2s.rready),
    .o_bvalid(o_s2m.bvalid),
    .o_rvalid(o_s2m.rvalid),
    .o_bresp (o_s2m.bresp),
    .o_rresp (o_s2m.rresp),
    .o_rdata (o_s2m.rdata),
    .o_done  (done)
  );

endmodule

// File: bench/axi4_sram_asserts.sv
`timescale 1ns/100ps

module axi4_sram_asserts (
  input logic                i_clk,
  input logic                i_rst_n,
  input axi4_pkg::axi4_m2s_t i_m2s,
  input axi4_pkg::axi4_s2m_t i_s2m
);

  // A write response under back-pressure keeps its valid and its code
  b_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_s2m.bvalid && !i_m2s.bready |=> i_s2m.bvalid && $stable(i_s2m.bresp))
    else $error("B channel changed before the master accepted it");

  // Same rule on the read channel, the data word included
  r_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_s2m.rvalid && !i_m2s.rready |=> i_s2m.rvalid && $stable(i_s2m.rresp)
      && $stable(i_s2m.rdata))
    else $error("R channel changed before the master accepted it");

  // Nothing may be accepted while reset is held
  reset_quiet: assert property (@(posedge i_clk)
    !i_rst_n |-> !(i_s2m.awready || i_s2m.wready || i_s2m.arready))
    else $error("A ready output was high during reset");

  // One transfer at a time, so no request is taken while a response waits
  busy_no_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_s2m.bvalid || i_s2m.rvalid)
      |-> !(i_s2m.awready || i_s2m.wready || i_s2m.arready))
    else $error("A ready output was high while a response was pending");

endmodule

bind axi4_sram axi4_sram_asserts axi4_sram_asserts_i (
  .i_clk  (i_clk),
  .i_rst_n(i_rst_n),
  .i_m2s  (i_m2s),
  .i_s2m  (o_s2m)
);

// File: bench/axi4_sram_tb.sv
`timescale 1ns/100ps
`include "sram_macros.svh"

module axi4_sram_tb;

  localparam int          CLK_PERIOD = 100;
  localparam int          QTR = CLK_PERIOD / 4;
  localparam logic [31:0] SEED = 32'h2029_5e26;
  // AXI response encodings
  localparam logic [1:0]  RESP_OK = 2'b00;
  localparam logic [1:0]  RESP_DE = 2'b11;

  typedef logic [`SRAM_DATA_BITS-1:0] word_t;
  // Write only, read only, or AW, W and AR raised together
  typedef enum logic [1:0] {K_WRITE, K_READ, K_BOTH} kind_e;
  typedef struct packed {
    kind_e                       kind;
    logic [`SRAM_ADDR_BITS-1:0]  addr;
    word_t                       wdata;
    logic [`SRAM_DATA_BYTES-1:0] strb;
    word_t                       exp_data;
    logic [1:0]                  exp_resp;
  } entry_t;

  logic                clk;
  logic                rst_n;
  axi4_pkg::axi4_m2s_t m2s;
  axi4_pkg::axi4_s2m_t s2m;
  entry_t              tests[$];
  string               names[$];
  int                  cycles = 0;
  int                  cycle_limit = 0;

  axi4_sram #(.XADDR(32'h0000_8000), .XMASK(32'h0000_0fff)) axi4_sram_i (
    .i_clk  (clk),
    .i_rst_n(rst_n),
    .i_m2s  (m2s),
    .o_s2m  (s2m)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Guards against a handshake that never comes
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("tests failed");
      $fatal(1, "Timeout: the run went past %0d clock cycles", cycle_limit);
    end
  end

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("tests failed");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  // AXI write strobe rule, each enabled lane takes the new byte
  function automatic word_t merge_lanes(input word_t old, input word_t data,
                                        input logic [`SRAM_DATA_BYTES-1:0] strb);
    word_t res;
    res = old;
    for (int i = 0; i < `SRAM_DATA_BYTES; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_entry(input string name, input kind_e kind,
                           input logic [`SRAM_ADDR_BITS-1:0] addr,
                           input word_t wdata, input logic [`SRAM_DATA_BYTES-1:0] strb,
                           input word_t exp_data, input logic [1:0] exp_resp);
    tests.push_back('{kind: kind, addr: addr, wdata: wdata, strb: strb,
                      exp_data: exp_data, exp_resp: exp_resp});
    names.push_back(name);
  endtask

  // Starts just after valid was driven on a falling edge, ends on the falling edge after the take
  task automatic wait_accept(input string name, input bit is_write);
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      #(QTR);
      taken = is_write ? s2m.awready : s2m.arready;
      if (taken && is_write) begin
        check_value({name, " wready"}, 32'(s2m.awready), 32'(s2m.wready));
        check_value({name, " arready"}, '0, 32'(s2m.arready));
      end
      @(negedge clk);
    end
    if (is_write) begin
      m2s.aw.valid = 1'b0;
      m2s.w.valid  = 1'b0;
    end else begin
      m2s.ar.valid = 1'b0;
    end
  endtask

  // Ready stays low for 0 to 3 cycles once the response is up
  // The response must not move while it waits
  task automatic await_response(input string name, input bit is_write,
                                input logic [1:0] exp_resp, input word_t exp_data);
    int         stall;
    bit         rdy;
    bit         seen;
    bit         taken;
    logic [1:0] held_resp;
    word_t      held_data;
    logic [1:0] cur_resp;
    word_t      cur_data;
    stall = int'($urandom % 4);
    seen  = 1'b0;
    taken = 1'b0;
    while (!taken) begin
      rdy        = (stall == 0);
      m2s.bready = is_write && rdy;
      m2s.rready = !is_write && rdy;
      #(QTR);
      cur_resp = is_write ? s2m.bresp : s2m.rresp;
      cur_data = is_write ? '0 : s2m.rdata;
      if (is_write ? s2m.bvalid : s2m.rvalid) begin
        if (seen) begin
          check_value({name, " resp held"}, 32'(held_resp), 32'(cur_resp));
          if (!is_write) begin
            check_value({name, " data held"}, held_data, cur_data);
          end
        end
        seen      = 1'b1;
        held_resp = cur_resp;
        held_data = cur_data;
        taken     = rdy;
        if (stall > 0) begin
          stall--;
        end
      end
      @(negedge clk);
    end
    check_value({name, " resp"}, 32'(exp_resp), 32'(held_resp));
    if (!is_write) begin
      check_value({name, " rdata"}, exp_data, held_data);
    end
  endtask

  initial begin
    entry_t e;
    word_t  word;
    void'($urandom(SEED));
    m2s   = '0;
    rst_n = 1'b0;
    // Partial writes track the expected word through the strobe rule
    word = 32'hdead_beef;
    add_entry("full write", K_WRITE, 32'h0000_8010, word, 4'hf, '0, RESP_OK);
    add_entry("full read", K_READ, 32'h0000_8010, '0, 4'h0, word, RESP_OK);
    add_entry("lane write 0 2", K_WRITE, 32'h0000_8010, 32'h1122_3344, 4'b0101, '0, RESP_OK);
    word = merge_lanes(word, 32'h1122_3344, 4'b0101);
    add_entry("merged read", K_READ, 32'h0000_8010, '0, 4'h0, word, RESP_OK);
    add_entry("lane write 3", K_WRITE, 32'h0000_8010, 32'ha5c3_9670, 4'b1000, '0, RESP_OK);
    word = merge_lanes(word, 32'ha5c3_9670, 4'b1000);
    add_entry("merged read 3", K_READ, 32'h0000_8010, '0, 4'h0, word, RESP_OK);
    // 0x9010 and 0x10008010 alias onto the word at 0x8010 but lie outside the window
    add_entry("outside write", K_WRITE, 32'h0000_9010, 32'h0bad_f00d, 4'hf, '0, RESP_DE);
    add_entry("outside read", K_READ, 32'h0000_9010, '0, 4'h0, '0, RESP_DE);
    add_entry("high outside read", K_READ, 32'h1000_8010, '0, 4'h0, '0, RESP_DE);
    add_entry("alias unchanged", K_READ, 32'h0000_8010, '0, 4'h0, word, RESP_OK);
    add_entry("top word write", K_WRITE, 32'h0000_8ffc, 32'h5a5a_0f0f, 4'hf, '0, RESP_OK);
    add_entry("top word read", K_READ, 32'h0000_8ffc, '0, 4'h0, 32'h5a5a_0f0f, RESP_OK);
    add_entry("write before read", K_BOTH, 32'h0000_8020, 32'h7e57_c0de, 4'hf,
              32'h7e57_c0de, RESP_OK);
    cycle_limit = tests.size() * 12 + 50;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    #(QTR);
    check_value("idle after reset", '0,
                32'({s2m.awready, s2m.wready, s2m.arready, s2m.bvalid, s2m.rvalid}));
    @(negedge clk);
    foreach (tests[i]) begin
      e = tests[i];
      if (e.kind != K_READ) begin
        m2s.aw = '{valid: 1'b1, addr: e.addr};
        m2s.w  = '{valid: 1'b1, data: e.wdata, strb: e.strb};
      end
      if (e.kind != K_WRITE) begin
        m2s.ar = '{valid: 1'b1, addr: e.addr};
      end
      // In the combined case the write goes first while AR keeps waiting
      if (e.kind != K_READ) begin
        wait_accept(names[i], 1'b1);
        await_response(names[i], 1'b1, e.exp_resp, '0);
      end
      if (e.kind != K_WRITE) begin
        wait_accept(names[i], 1'b0);
        await_response(names[i], 1'b0, e.exp_resp, e.exp_data);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/axi4_pkg.sv
rtl/sram_pkg.sv
rtl/axi4_req_stage.sv
rtl/sram_bytes.sv
rtl/axi4_resp_stage.sv
rtl/axi4_sram.sv
bench/axi4_sram_asserts.sv
bench/axi4_sram_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= axi4_sram_tb
SEED      ?= 1
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# Build the testbench and run it; a $fatal or a failed assertion gives a nonzero exit
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
